/* src/smartnic_pkg.sv */
package smartnic_pkg;

    // ====================
    // Stream widths
    // ====================
    localparam int DATA_W    = 64;
    localparam int NUM_PORTS = 2;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [0:0]        port_id_t;
    typedef logic [31:0]       count_t;
    typedef logic [31:0]       timestamp_t;

    // ====================
    // AXI4-Lite registers
    // ====================
    typedef logic [7:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    localparam axil_addr_t REG_CTRL      = 8'h00;
    localparam axil_addr_t REG_TIMESTAMP = 8'h04;
    localparam axil_addr_t REG_PKT0      = 8'h08;
    localparam axil_addr_t REG_PKT1      = 8'h0C;
    localparam axil_addr_t REG_DROP0     = 8'h10;
    localparam axil_addr_t REG_DROP1     = 8'h14;

    // Both ports enabled out of reset
    localparam logic [NUM_PORTS-1:0] CTRL_RESET = 2'b11;

    localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

    // ====================
    // State machines
    // ====================
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

    typedef enum logic {
        WR_IDLE = 1'b0,
        WR_RESP = 1'b1
    } axil_wr_state_e;

endpackage : smartnic_pkg

/* src/ingress_port.sv */
module ingress_port
    import smartnic_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   enable,

    input  data_t  s_tdata,
    input  logic   s_tvalid,
    input  logic   s_tlast,
    output logic   s_tready,

    output data_t  m_tdata,
    output logic   m_tvalid,
    output logic   m_tlast,
    input  logic   m_tready,

    output count_t pkt_count,
    output count_t drop_count
);

    logic in_pkt;
    logic drop_q;
    logic drop_beat;
    logic s_fire;

    // Output register empty or draining this cycle
    assign s_tready = !m_tvalid || m_tready;
    assign s_fire   = s_tvalid && s_tready;

    // First beat follows the live enable, later beats keep the latched decision
    assign drop_beat = in_pkt ? drop_q : !enable;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_pkt <= 1'b0;
            drop_q <= 1'b0;
        end else if (s_fire) begin
            in_pkt <= !s_tlast;
            drop_q <= drop_beat;
        end
    end

    // Packet counters, bumped on the last beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_count  <= '0;
            drop_count <= '0;
        end else if (s_fire && s_tlast) begin
            if (drop_beat) begin
                drop_count <= drop_count + 1'b1;
            end else begin
                pkt_count <= pkt_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_tvalid <= 1'b0;
        end else if (s_fire && !drop_beat) begin
            m_tvalid <= 1'b1;
        end else if (m_tready) begin
            m_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_fire && !drop_beat) begin
            m_tdata <= s_tdata;
            m_tlast <= s_tlast;
        end
    end

endmodule : ingress_port

/* src/egress_arbiter.sv */
module egress_arbiter
    import smartnic_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  data_t    in0_tdata,
    input  logic     in0_tvalid,
    input  logic     in0_tlast,
    output logic     in0_tready,

    input  data_t    in1_tdata,
    input  logic     in1_tvalid,
    input  logic     in1_tlast,
    output logic     in1_tready,

    output data_t    out_tdata,
    output logic     out_tvalid,
    output logic     out_tlast,
    output port_id_t out_tid,
    input  logic     out_tready
);

    arb_state_e state;
    port_id_t   grant;
    port_id_t   sel;
    data_t      sel_tdata;
    logic       sel_tvalid;
    logic       sel_tlast;
    logic       out_space;
    logic       take;

    // ====================
    // Port selection
    // ====================
    // Idle picks a valid port, preferring the one not served last
    always_comb begin
        sel = grant;
        if (state == ARB_IDLE) begin
            if (in0_tvalid && in1_tvalid) begin
                sel = ~grant;
            end else if (in1_tvalid) begin
                sel = 1'b1;
            end else begin
                sel = 1'b0;
            end
        end
    end

    assign sel_tdata  = sel ? in1_tdata  : in0_tdata;
    assign sel_tvalid = sel ? in1_tvalid : in0_tvalid;
    assign sel_tlast  = sel ? in1_tlast  : in0_tlast;

    assign out_space  = !out_tvalid || out_tready;
    assign take       = out_space && sel_tvalid;

    assign in0_tready = out_space && (sel == 1'b0);
    assign in1_tready = out_space && (sel == 1'b1);

    // Hold the grant until the packet's last beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            grant <= 1'b1;
        end else if (take) begin
            grant <= sel;
            state <= sel_tlast ? ARB_IDLE : ARB_BUSY;
        end
    end

    // ====================
    // Output register
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_tvalid <= 1'b0;
        end else if (take) begin
            out_tvalid <= 1'b1;
        end else if (out_tready) begin
            out_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_tdata <= sel_tdata;
            out_tlast <= sel_tlast;
            out_tid   <= sel;
        end
    end

endmodule : egress_arbiter

/* src/axil_regs.sv */
module axil_regs
    import smartnic_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    input  axil_addr_t           s_axil_awaddr,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  axil_data_t           s_axil_wdata,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    output logic [1:0]           s_axil_bresp,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,

    input  axil_addr_t           s_axil_araddr,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    output axil_data_t           s_axil_rdata,
    output logic [1:0]           s_axil_rresp,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready,

    output logic [NUM_PORTS-1:0] port_enable,
    input  count_t               pkt_count0,
    input  count_t               pkt_count1,
    input  count_t               drop_count0,
    input  count_t               drop_count1
);

    axil_wr_state_e       wr_state;
    logic                 wr_accept;
    logic                 rd_accept;
    logic [NUM_PORTS-1:0] ctrl_q;
    timestamp_t           timestamp;
    axil_data_t           rd_value;

    // Free-running timestamp
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    // ====================
    // Write channel
    // ====================
    // Address and data taken together, one response outstanding
    assign wr_accept      = (wr_state == WR_IDLE) && s_axil_awvalid && s_axil_wvalid;
    assign s_axil_awready = wr_accept;
    assign s_axil_wready  = wr_accept;
    assign s_axil_bvalid  = (wr_state == WR_RESP);
    assign s_axil_bresp   = AXIL_RESP_OKAY;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_accept) begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (s_axil_bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // Only the control register is writable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl_q <= CTRL_RESET;
        end else if (wr_accept && s_axil_awaddr == REG_CTRL) begin
            ctrl_q <= s_axil_wdata[NUM_PORTS-1:0];
        end
    end

    assign port_enable = ctrl_q;

    // ====================
    // Read channel
    // ====================
    assign s_axil_arready = s_axil_arvalid && !s_axil_rvalid;
    assign rd_accept      = s_axil_arvalid && s_axil_arready;
    assign s_axil_rresp   = AXIL_RESP_OKAY;

    always_comb begin
        case (s_axil_araddr)
            REG_CTRL:      rd_value = axil_data_t'(ctrl_q);
            REG_TIMESTAMP: rd_value = timestamp;
            REG_PKT0:      rd_value = pkt_count0;
            REG_PKT1:      rd_value = pkt_count1;
            REG_DROP0:     rd_value = drop_count0;
            REG_DROP1:     rd_value = drop_count1;
            // Unmapped reads as zero
            default:       rd_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_axil_rvalid <= 1'b0;
        end else if (rd_accept) begin
            s_axil_rvalid <= 1'b1;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    // Value captured at address acceptance
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            s_axil_rdata <= rd_value;
        end
    end

endmodule : axil_regs

/* src/smartnic_lite.sv */
module smartnic_lite
    import smartnic_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  data_t      in0_tdata,
    input  logic       in0_tvalid,
    input  logic       in0_tlast,
    output logic       in0_tready,

    input  data_t      in1_tdata,
    input  logic       in1_tvalid,
    input  logic       in1_tlast,
    output logic       in1_tready,

    output data_t      out_tdata,
    output logic       out_tvalid,
    output logic       out_tlast,
    output port_id_t   out_tid,
    input  logic       out_tready,

    input  axil_addr_t s_axil_awaddr,
    input  logic       s_axil_awvalid,
    output logic       s_axil_awready,
    input  axil_data_t s_axil_wdata,
    input  logic       s_axil_wvalid,
    output logic       s_axil_wready,
    output logic [1:0] s_axil_bresp,
    output logic       s_axil_bvalid,
    input  logic       s_axil_bready,
    input  axil_addr_t s_axil_araddr,
    input  logic       s_axil_arvalid,
    output logic       s_axil_arready,
    output axil_data_t s_axil_rdata,
    output logic [1:0] s_axil_rresp,
    output logic       s_axil_rvalid,
    input  logic       s_axil_rready
);

    logic [NUM_PORTS-1:0] port_enable;
    count_t               pkt_count0;
    count_t               pkt_count1;
    count_t               drop_count0;
    count_t               drop_count1;

    // Ingress stage outputs toward the arbiter
    data_t arb0_tdata;
    logic  arb0_tvalid;
    logic  arb0_tlast;
    logic  arb0_tready;
    data_t arb1_tdata;
    logic  arb1_tvalid;
    logic  arb1_tlast;
    logic  arb1_tready;

    // ====================
    // Ingress stages
    // ====================
    ingress_port u_ingress0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (port_enable[0]),
        .s_tdata    (in0_tdata),
        .s_tvalid   (in0_tvalid),
        .s_tlast    (in0_tlast),
        .s_tready   (in0_tready),
        .m_tdata    (arb0_tdata),
        .m_tvalid   (arb0_tvalid),
        .m_tlast    (arb0_tlast),
        .m_tready   (arb0_tready),
        .pkt_count  (pkt_count0),
        .drop_count (drop_count0)
    );

    ingress_port u_ingress1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (port_enable[1]),
        .s_tdata    (in1_tdata),
        .s_tvalid   (in1_tvalid),
        .s_tlast    (in1_tlast),
        .s_tready   (in1_tready),
        .m_tdata    (arb1_tdata),
        .m_tvalid   (arb1_tvalid),
        .m_tlast    (arb1_tlast),
        .m_tready   (arb1_tready),
        .pkt_count  (pkt_count1),
        .drop_count (drop_count1)
    );

    // ====================
    // Egress and registers
    // ====================
    egress_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .in0_tdata  (arb0_tdata),
        .in0_tvalid (arb0_tvalid),
        .in0_tlast  (arb0_tlast),
        .in0_tready (arb0_tready),
        .in1_tdata  (arb1_tdata),
        .in1_tvalid (arb1_tvalid),
        .in1_tlast  (arb1_tlast),
        .in1_tready (arb1_tready),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tlast  (out_tlast),
        .out_tid    (out_tid),
        .out_tready (out_tready)
    );

    axil_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .port_enable    (port_enable),
        .pkt_count0     (pkt_count0),
        .pkt_count1     (pkt_count1),
        .drop_count0    (drop_count0),
        .drop_count1    (drop_count1)
    );

endmodule : smartnic_lite

/* tb/tb_assertions.sv */
module tb_assertions
    import smartnic_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input data_t      out_tdata,
    input logic       out_tvalid,
    input logic       out_tlast,
    input port_id_t   out_tid,
    input logic       out_tready,
    input axil_addr_t s_axil_awaddr,
    input logic       s_axil_awvalid,
    input logic       s_axil_awready,
    input axil_data_t s_axil_wdata,
    input logic       s_axil_bvalid,
    input logic       s_axil_bready,
    input logic       s_axil_rvalid,
    input logic       s_axil_rready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic     p1_enable;
    logic     mid_pkt;
    port_id_t pkt_tid;

    // Port 1 enable as seen on accepted control writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            p1_enable <= CTRL_RESET[1];
        end else if (s_axil_awvalid && s_axil_awready && s_axil_awaddr == REG_CTRL) begin
            p1_enable <= s_axil_wdata[1];
        end
    end

    // Source of the packet currently on the egress stream
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mid_pkt <= 1'b0;
            pkt_tid <= '0;
        end else if (out_tvalid && out_tready) begin
            mid_pkt <= !out_tlast;
            pkt_tid <= out_tid;
        end
    end

    // ====================
    // Checks
    // ====================
    reset_idle: assert property (@(posedge clk)
        !rst_n |=> !out_tvalid && !s_axil_bvalid && !s_axil_rvalid)
        else $error("outputs not idle after reset");

    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_tvalid && !out_tready |=>
            out_tvalid && $stable(out_tdata) && $stable(out_tlast) && $stable(out_tid))
        else $error("egress beat changed while stalled");

    no_interleave: assert property (@(posedge clk) disable iff (!rst_n)
        out_tvalid && mid_pkt |-> out_tid == pkt_tid)
        else $error("egress packets interleaved");

    drop_port1: assert property (@(posedge clk) disable iff (!rst_n)
        out_tvalid |-> (out_tid == 1'b0 || p1_enable))
        else $error("beat from disabled port 1 reached egress");

    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
        else $error("rvalid dropped before rready");

endmodule : tb_assertions

/* tb/tb.sv */
module tb
    import smartnic_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic       clk = 1'b0;
    logic       rst_n;
    int         seed = 86120;
    int         cycles = 0;

    // Stream inputs per port, index 0 is the wire side
    data_t      tdata  [NUM_PORTS];
    logic       tvalid [NUM_PORTS];
    logic       tlast  [NUM_PORTS];
    logic       tready [NUM_PORTS];

    data_t      out_tdata;
    logic       out_tvalid;
    logic       out_tlast;
    port_id_t   out_tid;
    logic       out_tready;

    axil_addr_t s_axil_awaddr;
    logic       s_axil_awvalid;
    logic       s_axil_awready;
    axil_data_t s_axil_wdata;
    logic       s_axil_wvalid;
    logic       s_axil_wready;
    logic [1:0] s_axil_bresp;
    logic       s_axil_bvalid;
    logic       s_axil_bready;
    axil_addr_t s_axil_araddr;
    logic       s_axil_arvalid;
    logic       s_axil_arready;
    axil_data_t s_axil_rdata;
    logic [1:0] s_axil_rresp;
    logic       s_axil_rvalid;
    logic       s_axil_rready;

    // Expected state kept by the testbench
    logic [NUM_PORTS-1:0] port_en;
    int                   pkt_sent  [NUM_PORTS];
    int                   drop_sent [NUM_PORTS];
    int                   fwd_beats = 0;
    int                   out_beats = 0;

    // Forwarded beats per source port, tlast above the data
    logic [DATA_W:0]      exp_q     [NUM_PORTS][$];

    smartnic_lite smartnic_lite_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .in0_tdata      (tdata[0]),
        .in0_tvalid     (tvalid[0]),
        .in0_tlast      (tlast[0]),
        .in0_tready     (tready[0]),
        .in1_tdata      (tdata[1]),
        .in1_tvalid     (tvalid[1]),
        .in1_tlast      (tlast[1]),
        .in1_tready     (tready[1]),
        .out_tdata      (out_tdata),
        .out_tvalid     (out_tvalid),
        .out_tlast      (out_tlast),
        .out_tid        (out_tid),
        .out_tready     (out_tready),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready)
    );

    bind smartnic_lite tb_assertions tb_assertions_inst (.*);

    always #4 clk = ~clk;

    // Egress back-pressure, ready about three cycles in four
    always @(posedge clk) begin
        #1;
        out_tready = ($random(seed) & 3) != 0;
    end

    // Transfers counted mid-cycle, where valid and ready are settled
    always @(negedge clk) begin
        if (rst_n && out_tvalid && out_tready) begin
            check_egress_beat();
            out_beats++;
        end
    end

    // About ten times the expected run length
    always @(posedge clk) begin
        cycles++;
        if (cycles > 20000) begin
            report_failure("ERROR: timeout, traffic did not drain");
        end
    end

    // ====================
    // Helpers
    // ====================
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    // Returns 1 ns after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Egress beat against the oldest beat sent on its port
    task automatic check_egress_beat();
        logic [DATA_W:0] expected;
        if (exp_q[out_tid].size() == 0) begin
            report_failure($sformatf("egress beat from port %0d was never sent", out_tid));
        end else begin
            expected = exp_q[out_tid].pop_front();
            if (expected !== {out_tlast, out_tdata}) begin
                report_failure($sformatf("ERR egress%0d: expected %h, actual %h",
                                         out_tid, expected, {out_tlast, out_tdata}));
            end
        end
    endtask

    task automatic send_packets(input int port, input int num_pkts);
        int   len;
        int   gap;
        logic fwd;
        logic ok;
        for (int p = 0; p < num_pkts; p++) begin
            len = ($random(seed) & 7) + 1;
            fwd = port_en[port];
            for (int b = 0; b < len; b++) begin
                gap = $random(seed) & 1;
                if (gap != 0) begin
                    tvalid[port] = 1'b0;
                    next_cycle();
                end
                tdata[port]  = {$random(seed), $random(seed)};
                tlast[port]  = (b == len - 1);
                tvalid[port] = 1'b1;
                do begin
                    #2;
                    ok = tready[port];
                    next_cycle();
                end while (!ok);
                if (fwd) begin
                    fwd_beats++;
                    exp_q[port].push_back({tlast[port], tdata[port]});
                end
            end
            if (fwd) begin
                pkt_sent[port]++;
            end else begin
                drop_sent[port]++;
            end
        end
        tvalid[port] = 1'b0;
        tlast[port]  = 1'b0;
    endtask

    task automatic wait_drain();
        while (out_beats != fwd_beats) begin
            next_cycle();
        end
    endtask

    task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
        logic       ok;
        logic [1:0] resp;
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        do begin
            #2;
            ok = s_axil_awready;
            if (s_axil_wready !== s_axil_awready) begin
                report_failure("write address and write data were not accepted together");
            end
            next_cycle();
        end while (!ok);
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        // Late bready keeps bvalid waiting
        repeat ($random(seed) & 3) next_cycle();
        s_axil_bready = 1'b1;
        do begin
            #2;
            ok   = s_axil_bvalid;
            resp = s_axil_bresp;
            next_cycle();
        end while (!ok);
        s_axil_bready = 1'b0;
        // OKAY is the only response
        if (resp !== 2'b00) begin
            report_failure($sformatf("ERR bresp: expected 0, actual %0d", resp));
        end
    endtask

    task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
        logic       ok;
        logic [1:0] resp;
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        do begin
            #2;
            ok = s_axil_arready;
            next_cycle();
        end while (!ok);
        s_axil_arvalid = 1'b0;
        repeat ($random(seed) & 3) next_cycle();
        s_axil_rready = 1'b1;
        do begin
            #2;
            ok   = s_axil_rvalid;
            data = s_axil_rdata;
            resp = s_axil_rresp;
            next_cycle();
        end while (!ok);
        s_axil_rready = 1'b0;
        if (resp !== 2'b00) begin
            report_failure($sformatf("ERR rresp: expected 0, actual %0d", resp));
        end
    endtask

    task automatic check_reg(input string name, input axil_addr_t addr, input int expected);
        axil_data_t actual;
        read_reg(addr, actual);
        if (actual !== axil_data_t'(expected)) begin
            report_failure($sformatf("ERR %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    // ====================
    // Test sequence
    // ====================
    initial begin
        axil_data_t ts_first;
        axil_data_t ts_second;
        rst_n          = 1'b0;
        out_tready     = 1'b0;
        port_en        = CTRL_RESET;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            tdata[i]     = '0;
            tvalid[i]    = 1'b0;
            tlast[i]     = 1'b0;
            pkt_sent[i]  = 0;
            drop_sent[i] = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Both ports forwarding
        fork
            send_packets(0, 100);
            send_packets(1, 100);
        join
        wait_drain();

        // Port 1 off while the stream is idle
        write_reg(REG_CTRL, 32'h1);
        port_en = 2'b01;
        fork
            send_packets(0, 50);
            send_packets(1, 50);
        join
        wait_drain();

        check_reg("pkt0", REG_PKT0, pkt_sent[0]);
        check_reg("pkt1", REG_PKT1, pkt_sent[1]);
        check_reg("drop0", REG_DROP0, drop_sent[0]);
        check_reg("drop1", REG_DROP1, drop_sent[1]);
        check_reg("ctrl", REG_CTRL, 1);
        read_reg(REG_TIMESTAMP, ts_first);
        read_reg(REG_TIMESTAMP, ts_second);
        if (ts_second <= ts_first) begin
            report_failure($sformatf("ERR timestamp: expected more than %0d, actual %0d",
                                     ts_first, ts_second));
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule : tb

/* flist.f */
src/smartnic_pkg.sv
src/ingress_port.sv
src/egress_arbiter.sv
src/axil_regs.sv
src/smartnic_lite.sv
tb/tb_assertions.sv
tb/tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
